/* verilog/rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// ---------------------------------------------------------------------------
// core geometry
// ---------------------------------------------------------------------------

// data path and address width
`define RV_XLEN      32

// architectural registers, x0 included
`define RV_NREGS     32

// register index width, log2 of RV_NREGS
`define RV_REG_AW    5

// ---------------------------------------------------------------------------
// fixed values
// ---------------------------------------------------------------------------

// first fetch address after reset
`define RV_RESET_PC  32'h0000_0000

// ADDI x0,x0,0, fills flushed and reset slots
`define RV_NOP       32'h0000_0013

`endif

/* verilog/rv_pkg.sv */
`default_nettype none
`include "rv_settings.svh"

package rv_pkg;

  // ---------------------------------------------------------------------------
  // encodings
  // ---------------------------------------------------------------------------

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OP     = 7'b0110011, // add, sub, and, or
    OP_IMM = 7'b0010011, // addi
    LOAD   = 7'b0000011, // lw
    STORE  = 7'b0100011, // sw
    BRANCH = 7'b1100011, // beq, bne
    JAL    = 7'b1101111  // jal
  } opcode_e;

  typedef enum logic [1:0] {
    ADD = 2'b00,
    SUB = 2'b01,
    AND = 2'b10,
    OR  = 2'b11
  } alu_op_e;

  // write-back source
  typedef enum logic [1:0] {
    ALU = 2'b00, // alu result
    MEM = 2'b01, // load data
    PC4 = 2'b10  // link address
  } result_src_e;

  // ---------------------------------------------------------------------------
  // pipeline and port bundles
  // ---------------------------------------------------------------------------

  typedef struct packed {
    logic        reg_we;     // writes rd
    logic        mem_re;     // load
    logic        mem_we;     // store
    alu_op_e     alu_op;
    result_src_e result_src;
    logic        src_b_imm;  // alu b from immediate
    logic        src_a_pc;   // alu a from pc
    logic        branch;     // conditional branch
    logic        branch_ne;  // bne instead of beq
    logic        jump;       // unconditional jump
  } ctrl_t;

  typedef struct packed {
    logic                  valid;
    ctrl_t                 ctrl;
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_XLEN-1:0]   pc4;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;
    logic [`RV_XLEN-1:0]   imm;
    logic [`RV_REG_AW-1:0] rd;
  } id_ex_t;

  typedef struct packed {
    logic                  valid;
    logic                  reg_we;
    logic                  mem_re;
    logic                  mem_we;
    result_src_e           result_src;
    logic [`RV_XLEN-1:0]   alu_result; // also the memory address
    logic [`RV_XLEN-1:0]   store_data;
    logic [`RV_XLEN-1:0]   pc4;
    logic [`RV_REG_AW-1:0] rd;
  } ex_mem_t;

  typedef struct packed {
    logic                  reg_we;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   result;
  } mem_wb_t;

  typedef struct packed {
    logic                re;
    logic                we;
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] wdata;
  } dmem_req_t;

endpackage : rv_pkg

`default_nettype wire

/* verilog/rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_settings.svh"

module rv_fetch (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                redirect_i, // taken branch or jal in execute
  input  logic [`RV_XLEN-1:0] target_i,   // redirect address
  output logic [`RV_XLEN-1:0] pc_o        // address on the instruction port
);

  logic [`RV_XLEN-1:0] pc_q;    // current fetch address
  logic [`RV_XLEN-1:0] pc_next; // address for next cycle

  // sequential unless execute asks for a redirect
  assign pc_next = redirect_i ? target_i : pc_q + `RV_XLEN'(4);

  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
    begin
      pc_q <= `RV_RESET_PC; // restart vector
    end
    else
    begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;

endmodule : rv_fetch

`default_nettype wire

/* verilog/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_settings.svh"

module rv_regfile (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic [`RV_REG_AW-1:0] rs1_i,      // read address a
  input  logic [`RV_REG_AW-1:0] rs2_i,      // read address b
  output logic [`RV_XLEN-1:0]   rs1_data_o,
  output logic [`RV_XLEN-1:0]   rs2_data_o,
  input  rv_pkg::mem_wb_t       wb_i        // write port from write-back
);

  logic [`RV_XLEN-1:0] regs_q [`RV_NREGS]; // x0 entry never written

  // x0 reads zero, a same-cycle write is passed straight through
  function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_AW-1:0] addr);
    logic [`RV_XLEN-1:0] data;
    if (addr == '0)
      data = '0;
    else if (wb_i.reg_we && (wb_i.rd == addr))
      data = wb_i.result; // write-through
    else
      data = regs_q[addr];
    return data;
  endfunction

  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < `RV_NREGS; i++)
        regs_q[i] <= '0;
    end
    else if (wb_i.reg_we && (wb_i.rd != '0))
    begin
      regs_q[wb_i.rd] <= wb_i.result;
    end
  end

  always_comb
  begin
    rs1_data_o = read_port(rs1_i);
    rs2_data_o = read_port(rs2_i);
  end

endmodule : rv_regfile

`default_nettype wire

/* verilog/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_settings.svh"

module rv_decode (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic [31:0]         instr_i,  // from IF/ID
  input  logic [`RV_XLEN-1:0] pc_i,     // pc of instr_i
  input  logic                valid_i,  // IF/ID slot holds a live instruction
  input  rv_pkg::mem_wb_t     wb_i,     // register write from write-back
  output rv_pkg::id_ex_t      id_ex_o   // next ID/EX contents
);

  rv_pkg::opcode_e     opcode;
  logic [2:0]          funct3;
  logic                funct7_5;    // sub vs add
  rv_pkg::ctrl_t       ctrl;
  logic                known;       // opcode and funct in the subset
  logic [`RV_XLEN-1:0] imm;
  logic [`RV_XLEN-1:0] imm_i_type;
  logic [`RV_XLEN-1:0] imm_s_type;
  logic [`RV_XLEN-1:0] imm_b_type;
  logic [`RV_XLEN-1:0] imm_j_type;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;

  assign opcode   = rv_pkg::opcode_e'(instr_i[6:0]);
  assign funct3   = instr_i[14:12];
  assign funct7_5 = instr_i[30];

  // ---------------------------------------------------------------------------
  // immediates, all sign extended from instr[31]
  // ---------------------------------------------------------------------------
  assign imm_i_type = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{(`RV_XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                       instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_j_type = {{(`RV_XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                       instr_i[20], instr_i[30:21], 1'b0};

  // ---------------------------------------------------------------------------
  // control decode
  // ---------------------------------------------------------------------------
  always_comb
  begin
    ctrl        = '0;            // bubble by default
    ctrl.alu_op = rv_pkg::ADD;
    known       = 1'b1;
    imm         = imm_i_type;
    case (opcode)
      rv_pkg::OP:
      begin
        ctrl.reg_we = 1'b1;
        case (funct3)
          3'b000:  ctrl.alu_op = funct7_5 ? rv_pkg::SUB : rv_pkg::ADD;
          3'b111:  ctrl.alu_op = rv_pkg::AND;
          3'b110:  ctrl.alu_op = rv_pkg::OR;
          default: known = 1'b0; // shifts, compares, xor dropped
        endcase
      end
      rv_pkg::OP_IMM:
      begin
        ctrl.reg_we    = 1'b1;
        ctrl.src_b_imm = 1'b1;
        known          = (funct3 == 3'b000); // addi only
      end
      rv_pkg::LOAD:
      begin
        ctrl.reg_we     = 1'b1;
        ctrl.mem_re     = 1'b1;
        ctrl.src_b_imm  = 1'b1;          // rs1 + offset
        ctrl.result_src = rv_pkg::MEM;
        known           = (funct3 == 3'b010); // word only
      end
      rv_pkg::STORE:
      begin
        ctrl.mem_we    = 1'b1;
        ctrl.src_b_imm = 1'b1;
        imm            = imm_s_type;
        known          = (funct3 == 3'b010);
      end
      rv_pkg::BRANCH:
      begin
        ctrl.branch    = 1'b1;
        ctrl.branch_ne = funct3[0];      // 000 beq, 001 bne
        imm            = imm_b_type;
        known          = (funct3[2:1] == 2'b00);
      end
      rv_pkg::JAL:
      begin
        ctrl.reg_we     = 1'b1;
        ctrl.jump       = 1'b1;
        ctrl.src_a_pc   = 1'b1;          // alu forms pc + offset
        ctrl.src_b_imm  = 1'b1;
        ctrl.result_src = rv_pkg::PC4;   // link value
        imm             = imm_j_type;
      end
      default: known = 1'b0;
    endcase
  end

  rv_regfile rv_regfile_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rs1_i      (instr_i[19:15]),
    .rs2_i      (instr_i[24:20]),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wb_i       (wb_i)
  );

  always_comb
  begin
    id_ex_o.valid    = valid_i & known; // unknown opcode goes down as a bubble
    id_ex_o.ctrl     = known ? ctrl : '0;
    id_ex_o.pc       = pc_i;
    id_ex_o.pc4      = pc_i + `RV_XLEN'(4);
    id_ex_o.rs1_data = rs1_data;
    id_ex_o.rs2_data = rs2_data;
    id_ex_o.imm      = imm;
    id_ex_o.rd       = instr_i[11:7];
  end

endmodule : rv_decode

`default_nettype wire

/* verilog/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_settings.svh"

module rv_execute (
  input  rv_pkg::id_ex_t      id_ex_i,    // from ID/EX
  output rv_pkg::ex_mem_t     ex_mem_o,   // next EX/MEM contents
  output logic                redirect_o, // flush and refetch
  output logic [`RV_XLEN-1:0] target_o    // branch or jump destination
);

  logic [`RV_XLEN-1:0] src_a;
  logic [`RV_XLEN-1:0] src_b;
  logic [`RV_XLEN-1:0] alu_y;
  logic                equal;   // rs1 == rs2
  logic                taken;   // branch condition met

  // ---------------------------------------------------------------------------
  // alu
  // ---------------------------------------------------------------------------
  assign src_a = id_ex_i.ctrl.src_a_pc  ? id_ex_i.pc  : id_ex_i.rs1_data;
  assign src_b = id_ex_i.ctrl.src_b_imm ? id_ex_i.imm : id_ex_i.rs2_data;

  always_comb
  begin
    case (id_ex_i.ctrl.alu_op)
      rv_pkg::ADD: alu_y = src_a + src_b; // also address add for lw/sw
      rv_pkg::SUB: alu_y = src_a - src_b;
      rv_pkg::AND: alu_y = src_a & src_b;
      rv_pkg::OR:  alu_y = src_a | src_b;
      default:     alu_y = src_a + src_b;
    endcase
  end

  // ---------------------------------------------------------------------------
  // branch resolution
  // ---------------------------------------------------------------------------
  assign equal = (id_ex_i.rs1_data == id_ex_i.rs2_data);
  assign taken = id_ex_i.ctrl.branch & (id_ex_i.ctrl.branch_ne ? ~equal : equal);

  // only a live slot may steer fetch
  assign redirect_o = id_ex_i.valid & (taken | id_ex_i.ctrl.jump);
  assign target_o   = id_ex_i.pc + id_ex_i.imm; // b and j offsets are pc relative

  always_comb
  begin
    ex_mem_o.valid      = id_ex_i.valid;
    ex_mem_o.reg_we     = id_ex_i.ctrl.reg_we;
    ex_mem_o.mem_re     = id_ex_i.ctrl.mem_re;
    ex_mem_o.mem_we     = id_ex_i.ctrl.mem_we;
    ex_mem_o.result_src = id_ex_i.ctrl.result_src;
    ex_mem_o.alu_result = alu_y;
    ex_mem_o.store_data = id_ex_i.rs2_data; // sw data
    ex_mem_o.pc4        = id_ex_i.pc4;
    ex_mem_o.rd         = id_ex_i.rd;
  end

endmodule : rv_execute

`default_nettype wire

/* verilog/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_settings.svh"

module rv_core (
  input  logic                clk_i,
  input  logic                rst_i,
  // instruction port, data valid in the same cycle
  output logic [`RV_XLEN-1:0] imem_addr_o,
  input  logic [31:0]         imem_data_i,
  // data port, read data valid in the same cycle as re
  output rv_pkg::dmem_req_t   dmem_req_o,
  input  logic [`RV_XLEN-1:0] dmem_rdata_i
);

  logic [`RV_XLEN-1:0] pc;            // fetch address
  logic                ex_redirect;   // taken branch or jal in execute
  logic [`RV_XLEN-1:0] ex_target;

  logic [31:0]         if_id_instr_q; // IF/ID
  logic [`RV_XLEN-1:0] if_id_pc_q;
  logic                if_id_valid_q;

  rv_pkg::id_ex_t      id_ex_d;
  rv_pkg::id_ex_t      id_ex_q;
  rv_pkg::ex_mem_t     ex_mem_d;
  rv_pkg::ex_mem_t     ex_mem_q;
  rv_pkg::mem_wb_t     mem_wb_d;
  rv_pkg::mem_wb_t     mem_wb_q;
  logic [`RV_XLEN-1:0] wb_result;     // selected write-back value

  // ---------------------------------------------------------------------------
  // fetch
  // ---------------------------------------------------------------------------
  rv_fetch rv_fetch_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .redirect_i (ex_redirect),
    .target_i   (ex_target),
    .pc_o       (pc)
  );

  assign imem_addr_o = pc;

  // IF/ID, slot killed on redirect
  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
    begin
      if_id_instr_q <= `RV_NOP;
      if_id_pc_q    <= `RV_RESET_PC;
      if_id_valid_q <= 1'b0;
    end
    else
    begin
      if_id_instr_q <= ex_redirect ? `RV_NOP : imem_data_i;
      if_id_pc_q    <= pc;
      if_id_valid_q <= ~ex_redirect;
    end
  end

  // ---------------------------------------------------------------------------
  // decode
  // ---------------------------------------------------------------------------
  rv_decode rv_decode_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .instr_i (if_id_instr_q),
    .pc_i    (if_id_pc_q),
    .valid_i (if_id_valid_q),
    .wb_i    (mem_wb_q),      // register write lands in the write-back cycle
    .id_ex_o (id_ex_d)
  );

  // ID/EX, second bubble of a flush
  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
    begin
      id_ex_q <= '0;
    end
    else
    begin
      id_ex_q       <= id_ex_d;
      id_ex_q.valid <= id_ex_d.valid & ~ex_redirect;
    end
  end

  // ---------------------------------------------------------------------------
  // execute
  // ---------------------------------------------------------------------------
  rv_execute rv_execute_inst (
    .id_ex_i    (id_ex_q),
    .ex_mem_o   (ex_mem_d),
    .redirect_o (ex_redirect),
    .target_o   (ex_target)
  );

  // EX/MEM, the branch itself keeps going
  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
      ex_mem_q <= '0;
    else
      ex_mem_q <= ex_mem_d;
  end

  // ---------------------------------------------------------------------------
  // memory, loads and stores both issue here
  // ---------------------------------------------------------------------------
  always_comb
  begin
    dmem_req_o.re    = ex_mem_q.valid & ex_mem_q.mem_re;
    dmem_req_o.we    = ex_mem_q.valid & ex_mem_q.mem_we; // written at the next edge
    dmem_req_o.addr  = ex_mem_q.alu_result;
    dmem_req_o.wdata = ex_mem_q.store_data;
  end

  // write-back select ahead of MEM/WB
  always_comb
  begin
    case (ex_mem_q.result_src)
      rv_pkg::MEM: wb_result = dmem_rdata_i;  // lw
      rv_pkg::PC4: wb_result = ex_mem_q.pc4;  // jal link
      default:     wb_result = ex_mem_q.alu_result;
    endcase
  end

  assign mem_wb_d.reg_we = ex_mem_q.valid & ex_mem_q.reg_we;
  assign mem_wb_d.rd     = ex_mem_q.rd;
  assign mem_wb_d.result = wb_result;

  // MEM/WB, drives the register file write port
  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
      mem_wb_q <= '0;
    else
      mem_wb_q <= mem_wb_d;
  end

endmodule : rv_core

`default_nettype wire

/* bench/rv_tb_model.svh */
`ifndef RV_TB_MODEL_SVH
`define RV_TB_MODEL_SVH

// ---------------------------------------------------------------------------
// instruction encoders, fields taken from plain ints
// ---------------------------------------------------------------------------

// add/sub (f3 000), and (111), or (110)
function automatic logic [31:0] reg_op(input int f3, input int sub, input int rd,
                                       input int rs1, input int rs2);
  return {1'b0, sub[0], 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
  return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
endfunction

function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
  return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
endfunction

function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
  return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011}; // s-type split
endfunction

// f3 0 is beq, 1 is bne
function automatic logic [31:0] branch(input int f3, input int rs1, input int rs2,
                                       input int off);
  return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] jal(input int rd, input int off);
  return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
endfunction

// append at the end of the program
function automatic void put(input logic [31:0] word);
  imem[prog_len] = word;
  prog_len++;
endfunction

// three independent slots between a write and its first read
function automatic void gap();
  for (int i = 0; i < 3; i++)
    put(addi(0, 0, 0));
endfunction

// ---------------------------------------------------------------------------
// stimulus sources
// ---------------------------------------------------------------------------

function automatic logic lfsr_bit();
  logic fb;
  fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]; // x^32+x^22+x^2+x+1
  lfsr_q = {lfsr_q[30:0], fb};
  return fb;
endfunction

// one lfsr step per immediate bit, sign extended
function automatic int rand_imm12();
  logic [11:0] v;
  v = '0;
  for (int i = 0; i < 12; i++)
    v = {v[10:0], lfsr_bit()};
  return {{20{v[11]}}, v};
endfunction

// power-up contents, every address bit matters
function automatic logic [31:0] fill_word(input int idx);
  return {idx[15:0] ^ 16'hc3a5, ~idx[15:0]};
endfunction

// ---------------------------------------------------------------------------
// instruction-set model, one instruction per step
// ---------------------------------------------------------------------------

// taken branches and jal skip their two followers, so plain sequential
// semantics give the expected store stream
function automatic void build_expected();
  logic [31:0]       regs [32];
  logic [31:0]       mem [DMEM_WORDS];
  logic [31:0]       pc;
  logic [31:0]       ins;
  logic [31:0]       a;
  logic [31:0]       b;
  logic [31:0]       addr;
  logic [31:0]       wval;
  logic [31:0]       next_pc;
  logic              wen;
  logic              done;
  rv_pkg::dmem_req_t req;
  for (int i = 0; i < 32; i++)
    regs[i] = '0;
  for (int i = 0; i < DMEM_WORDS; i++)
    mem[i] = fill_word(i);
  expected_q.delete();
  pc   = `RV_RESET_PC;
  done = 1'b0;
  for (int step = 0; step < IMEM_WORDS && !done; step++)
  begin
    ins     = imem[pc[IMEM_AW+1:2]];
    a       = regs[ins[19:15]];
    b       = regs[ins[24:20]];
    next_pc = pc + 32'd4;
    wen     = 1'b0;
    wval    = '0;
    case (ins[6:0])
      7'b0110011: // register-register
      begin
        wen = 1'b1;
        case (ins[14:12])
          3'b000:  wval = ins[30] ? a - b : a + b;
          3'b111:  wval = a & b;
          default: wval = a | b;
        endcase
      end
      7'b0010011: // addi
      begin
        wen  = 1'b1;
        wval = a + {{20{ins[31]}}, ins[31:20]};
      end
      7'b0000011: // lw
      begin
        addr = a + {{20{ins[31]}}, ins[31:20]};
        wen  = 1'b1;
        wval = mem[addr[DMEM_AW+1:2]];
      end
      7'b0100011: // sw, recorded in order
      begin
        addr      = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        req.re    = 1'b0;
        req.we    = 1'b1;
        req.addr  = addr;
        req.wdata = b;
        mem[addr[DMEM_AW+1:2]] = b;
        expected_q.push_back(req);
        done = (addr == SENTINEL_ADDR);
      end
      7'b1100011: // beq / bne on funct3[0]
      begin
        if ((a == b) ^ ins[12])
          next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      7'b1101111: // jal
      begin
        wen     = 1'b1;
        wval    = pc + 32'd4;
        next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      default: ;
    endcase
    if (wen && ins[11:7] != 5'd0)
      regs[ins[11:7]] = wval; // x0 stays zero
    pc = next_pc;
  end
endfunction

`endif

/* bench/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_settings.svh"

module rv_core_tb;

  localparam int          CLK_PERIOD    = 100;
  localparam int          RESET_CYCLES  = 16;
  localparam int          IMEM_AW       = 8;             // 256 instruction words
  localparam int          IMEM_WORDS    = 1 << IMEM_AW;
  localparam int          DMEM_AW       = 10;            // 1024 data words
  localparam int          DMEM_WORDS    = 1 << DMEM_AW;
  localparam logic [31:0] MARK_ADDR     = 32'h0000_03f0; // only skipped slots store here
  localparam logic [31:0] SENTINEL_ADDR = 32'h0000_07fc; // last store of the program

  logic                clk_i;
  logic                rst_i;
  logic [`RV_XLEN-1:0] imem_addr_o;
  logic [31:0]         imem_data_i;
  rv_pkg::dmem_req_t   dmem_req_o;
  logic [`RV_XLEN-1:0] dmem_rdata_i;

  logic [31:0]         imem [IMEM_WORDS];
  logic [31:0]         dmem [DMEM_WORDS];
  int                  prog_len;          // words placed so far
  logic [31:0]         lfsr_q;
  rv_pkg::dmem_req_t   expected_q [$];    // stores in program order
  int                  store_idx;         // next expected store
  logic                sentinel_seen;
  int                  cycle_cnt;
  int                  timeout_limit;

  `include "rv_tb_model.svh"

  rv_core rv_core_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .imem_addr_o  (imem_addr_o),
    .imem_data_i  (imem_data_i),
    .dmem_req_o   (dmem_req_o),
    .dmem_rdata_i (dmem_rdata_i)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ---------------------------------------------------------------------------
  // memory models answering in the same cycle
  // ---------------------------------------------------------------------------
  assign imem_data_i  = imem[imem_addr_o[IMEM_AW+1:2]];

  // true word only while re is high
  assign dmem_rdata_i = dmem_req_o.re ? dmem[dmem_req_o.addr[DMEM_AW+1:2]]
                                      : ~dmem[dmem_req_o.addr[DMEM_AW+1:2]];

  always @(posedge clk_i)
  begin
    if (dmem_req_o.we === 1'b1)
      dmem[dmem_req_o.addr[DMEM_AW+1:2]] <= dmem_req_o.wdata; // word write
  end

  // ---------------------------------------------------------------------------
  // checks
  // ---------------------------------------------------------------------------
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic compare_req(input string name, input rv_pkg::dmem_req_t got,
                             input rv_pkg::dmem_req_t exp);
    if (got !== exp)
      stop_run($sformatf("Error: %s is %h, expected %h (store %0d)",
                         name, got, exp, store_idx));
  endtask

  task automatic compare_addr(input string name, input logic [`RV_XLEN-1:0] got,
                              input logic [`RV_XLEN-1:0] exp);
    if (got !== exp)
      stop_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
  endtask

  // pipeline empty and fetch parked at the reset vector
  task automatic check_idle();
    compare_addr("imem_addr_o", imem_addr_o, `RV_RESET_PC);
    compare_flag("dmem_req_o.we", dmem_req_o.we, 1'b0);
    compare_flag("dmem_req_o.re", dmem_req_o.re, 1'b0);
  endtask

  // mid-cycle sample of every store
  always @(negedge clk_i)
  begin
    if (dmem_req_o.we === 1'b1)
    begin
      if (store_idx >= expected_q.size())
        stop_run($sformatf("extra store to address %h after the end of the program",
                           dmem_req_o.addr));
      else
      begin
        compare_req("dmem_req_o", dmem_req_o, expected_q[store_idx]);
        if (dmem_req_o.addr == SENTINEL_ADDR)
        begin
          if (store_idx != expected_q.size() - 1)
            stop_run("end-of-program store came before all expected stores");
          else
            sentinel_seen = 1'b1;
        end
        store_idx++;
      end
    end
  end

  always @(posedge clk_i)
  begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_limit)
      stop_run($sformatf("timeout after %0d cycles with %0d of %0d stores seen",
                         cycle_cnt, store_idx, expected_q.size()));
  end

  // ---------------------------------------------------------------------------
  // test program with three slots between a write and its read
  // ---------------------------------------------------------------------------
  task automatic build_program();
    int r;
    for (int i = 0; i < IMEM_WORDS; i++)
      imem[i] = `RV_NOP;
    prog_len = 0;
    for (int i = 0; i < 8; i++)
    begin
      r = 1 + (i % 4);                                  // x1..x4 then chained on themselves
      put(addi(r, (i < 4) ? 0 : r, rand_imm12()));
    end
    gap();
    put(reg_op(0, 0, 5, 1, 2));                         // add x5
    put(reg_op(0, 1, 6, 3, 4));                         // sub x6
    put(reg_op(7, 0, 7, 1, 3));                         // and x7
    put(reg_op(6, 0, 8, 2, 4));                         // or x8
    gap();
    for (int i = 1; i <= 8; i++)
      put(sw(i, 0, 'h100 + 4 * (i - 1)));
    put(lw(9, 0, 'h100));                               // loads back into new registers
    put(lw(10, 0, 'h104));
    put(lw(11, 0, 'h11c));
    put(addi(12, 0, 'h100));                            // base register
    gap();
    put(lw(13, 12, 'h14));
    put(sw(9, 0, 'h200));
    put(sw(10, 0, 'h204));
    put(sw(11, 0, 'h208));
    put(sw(13, 12, 'h10c));                             // 0x20c through the base
    put(addi(14, 0, 5));
    put(addi(15, 0, 5));
    put(addi(16, 0, 7));
    gap();
    put(branch(0, 14, 15, 12));                         // beq taken
    put(sw(16, 0, MARK_ADDR));
    put(sw(16, 0, MARK_ADDR));
    put(sw(14, 0, 'h230));
    put(branch(0, 14, 16, 12));                         // beq falls through
    put(sw(14, 0, 'h234));
    put(sw(16, 0, 'h238));
    put(sw(15, 0, 'h23c));
    put(branch(1, 14, 16, 12));                         // bne taken
    put(sw(16, 0, MARK_ADDR));
    put(sw(16, 0, MARK_ADDR));
    put(sw(16, 0, 'h240));
    put(branch(1, 14, 15, 12));                         // bne falls through
    put(sw(15, 0, 'h244));
    put(sw(14, 0, 'h248));
    put(jal(17, 12));                                   // link into x17
    put(sw(17, 0, MARK_ADDR));
    put(sw(17, 0, MARK_ADDR));
    gap();                                              // first slot is the jal target
    put(sw(17, 0, 'h250));
    put(addi(0, 0, 'h123));                             // x0 writes are dropped
    put(reg_op(0, 0, 0, 1, 2));
    put(lw(0, 0, 'h100));
    gap();
    put(sw(0, 0, 'h260));
    put(sw(1, 0, SENTINEL_ADDR));
    put(jal(0, 0));                                     // park here
  endtask

  initial
  begin
    clk_i         = 1'b0;
    rst_i         = 1'b1;
    lfsr_q        = 32'hd3d4;
    store_idx     = 0;
    sentinel_seen = 1'b0;
    cycle_cnt     = 0;
    for (int i = 0; i < DMEM_WORDS; i++)
      dmem[i] = fill_word(i);
    build_program();
    build_expected();
    timeout_limit = RESET_CYCLES + 8 * prog_len;
    repeat (RESET_CYCLES)
    begin
      @(negedge clk_i);
      check_idle();
    end
    rst_i = 1'b0;                     // released on a falling edge
    #(CLK_PERIOD / 4);
    check_idle();                     // first cycle out of reset
    wait (sentinel_seen);
    repeat (8) @(negedge clk_i);      // room for stray stores
    $display("=== PASS ===");
    $finish;
  end

endmodule : rv_core_tb

`default_nettype wire

/* vlog.f */
+incdir+verilog
+incdir+bench
verilog/rv_pkg.sv
verilog/rv_fetch.sv
verilog/rv_regfile.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_core.sv
bench/rv_core_tb.sv

/* Makefile */
# Verilator build and run for the rv_core testbench

VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard verilog/*.svh bench/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source, header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM)
	$(SIM)

clean:
	rm -rf $(OBJ_DIR)
